// File: rtl/mac_rx_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types of the mac receive path
// word and status structs, monitor states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mac_rx_pkg;

    typedef logic [7:0]  byte_t;        // one byte from the mac core
    typedef logic [31:0] word_t;
    typedef logic [3:0]  keep_t;        // bit 0 is the first byte
    typedef logic [10:0] frame_len_t;   // up to 2047 bytes
    typedef logic [15:0] frame_cnt_t;   // wraps

    // packed word as it moves from packer to output
    typedef struct packed {
        word_t data;
        keep_t keep;
        logic  last;
    } rx_word_s;

    // per-frame verdict from the monitor
    typedef struct packed {
        logic       bad;    // err | runt | giant
        logic       err;
        logic       runt;
        logic       giant;
        frame_len_t len;
    } rx_status_s;

    typedef enum logic [1:0] {
        IDLE,
        IN_FRAME,
        HUNT        // dropping bytes until next sof
    } mon_state_e;

endpackage

// File: rtl/rx_word_packer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte to 32-bit word packer
// little endian lanes, keep and last
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rx_word_packer
    import mac_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  byte_t    rx_data,
    input  logic     rx_valid,
    input  logic     rx_sof,
    input  logic     rx_eof,
    output logic     word_stb,
    output rx_word_s word
);

    logic [1:0] idx;        // next free lane
    logic       in_frame;
    word_t      data_acc;

    logic       take;
    logic [1:0] lane;
    word_t      data_nxt;
    keep_t      keep_nxt;
    logic       emit;

    always_comb begin
        take = rx_valid && (rx_sof || in_frame);
        lane = rx_sof ? 2'd0 : idx;
        data_nxt = rx_sof ? '0 : data_acc;  // fresh word on sof
        data_nxt[lane*8 +: 8] = rx_data;
        emit = take && (lane == 2'd3 || rx_eof);
        case (lane)
            2'd0:    keep_nxt = 4'b0001;
            2'd1:    keep_nxt = 4'b0011;
            2'd2:    keep_nxt = 4'b0111;
            default: keep_nxt = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx      <= 2'd0;
            in_frame <= 1'b0;
            word_stb <= 1'b0;
        end else begin
            word_stb <= emit;
            if (take) begin
                if (rx_eof) begin
                    idx      <= 2'd0;
                    in_frame <= 1'b0;
                end else begin
                    idx      <= lane + 2'd1;    // wraps to 0 after lane 3
                    in_frame <= 1'b1;
                end
            end
        end
    end

    // lanes are cleared after each emitted word so unkept bytes read zero
    always_ff @(posedge clk) begin
        if (take) begin
            data_acc <= emit ? '0 : data_nxt;
        end
        if (emit) begin
            word.data <= data_nxt;
            word.keep <= keep_nxt;
            word.last <= rx_eof;
        end
    end

endmodule

// File: rtl/rx_frame_monitor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame length and error monitor
// one status strobe per frame
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rx_frame_monitor
    import mac_rx_pkg::*;
#(
    parameter int MIN_FRAME_LEN = 64,
    parameter int MAX_FRAME_LEN = 1518
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_valid,
    input  logic       rx_sof,
    input  logic       rx_eof,
    input  logic       rx_err,
    output logic       stat_stb,
    output rx_status_s stat
);

    mon_state_e state;
    frame_len_t len_cnt;
    logic       err_seen;

    logic       take;
    frame_len_t len_nxt;
    logic       err_nxt;
    logic       runt_nxt;
    logic       giant_nxt;

    always_comb begin
        take = rx_valid && (rx_sof || state == IN_FRAME);
        if (rx_sof) begin                   // restart, also inside a frame
            len_nxt = frame_len_t'(1);
            err_nxt = rx_err;
        end else begin
            len_nxt = (&len_cnt) ? len_cnt : len_cnt + 1'b1;   // saturate
            err_nxt = err_seen | rx_err;
        end
        runt_nxt  = len_nxt < frame_len_t'(MIN_FRAME_LEN);
        giant_nxt = len_nxt > frame_len_t'(MAX_FRAME_LEN);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            len_cnt  <= '0;
            err_seen <= 1'b0;
            stat_stb <= 1'b0;
        end else begin
            stat_stb <= take && rx_eof;
            if (take) begin
                len_cnt  <= len_nxt;
                err_seen <= err_nxt;
            end
            if (rx_valid) begin
                if (rx_sof) begin
                    state <= rx_eof ? IDLE : IN_FRAME;
                end else begin
                    case (state)
                        IN_FRAME: if (rx_eof) state <= IDLE;
                        IDLE:     state <= HUNT;    // stray byte outside a frame
                        default:  state <= HUNT;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && rx_eof) begin
            stat.len   <= len_nxt;
            stat.err   <= err_nxt;
            stat.runt  <= runt_nxt;
            stat.giant <= giant_nxt;
            stat.bad   <= err_nxt | runt_nxt | giant_nxt;
        end
    end

    a_stat_single : assert property (@(posedge clk) disable iff (!rst_n)
        stat_stb |=> !stat_stb);

endmodule

// File: rtl/rx_word_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fall-through word fifo
// drops writes when full, sticky overflow
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rx_word_fifo
    import mac_rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 512      // power of two
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_stb,
    input  rx_word_s wr_word,
    output rx_word_s q,
    output logic     q_valid,
    input  logic     q_pop,
    output logic     overflow
);

    localparam int AW = $clog2(FIFO_DEPTH);

    rx_word_s mem [0:FIFO_DEPTH-1];

    // one extra bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        wr_ok;

    assign full    = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_ok   = wr_stb && !full;
    assign q_valid = (wr_ptr != rd_ptr);
    assign q       = mem[rd_ptr[AW-1:0]];     // head shows without a read

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[AW-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_stb && full) begin
                overflow <= 1'b1;           // held until reset
            end
        end
    end

    a_pop_nonempty : assert property (@(posedge clk) disable iff (!rst_n)
        q_pop |-> q_valid);

endmodule

// File: rtl/rx_frame_tagger.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame tagger and output stream
// status queue, good and bad counters
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module rx_frame_tagger
    import mac_rx_pkg::*;
#(
    parameter int STAT_DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stat_stb,
    input  rx_status_s stat,
    input  rx_word_s   q,
    input  logic       q_valid,
    output logic       q_pop,
    output word_t      m_data,
    output keep_t      m_keep,
    output logic       m_last,
    output logic       m_bad,
    output frame_len_t m_len,
    output logic       m_valid,
    input  logic       m_ready,
    output frame_cnt_t good_frames,
    output frame_cnt_t bad_frames
);

    localparam int SW = $clog2(STAT_DEPTH);

    rx_status_s stat_mem [0:STAT_DEPTH-1];

    logic [SW:0] s_wr;
    logic [SW:0] s_rd;
    logic        stat_valid;
    logic        stat_full;
    rx_status_s  head;
    logic        frame_done;

    assign stat_valid = (s_wr != s_rd);
    assign stat_full  = (s_wr[SW] != s_rd[SW]) && (s_wr[SW-1:0] == s_rd[SW-1:0]);
    assign head       = stat_mem[s_rd[SW-1:0]];

    // a last word needs its status before it may leave
    assign m_valid    = q_valid && (!q.last || stat_valid);
    assign q_pop      = m_valid && m_ready;
    assign frame_done = q_pop && q.last;

    assign m_data = q.data;
    assign m_keep = q.keep;
    assign m_last = q.last;
    assign m_bad  = q.last ? head.bad : 1'b0;
    assign m_len  = q.last ? head.len : '0;

    always_ff @(posedge clk) begin
        if (stat_stb && !stat_full) begin
            stat_mem[s_wr[SW-1:0]] <= stat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_wr        <= '0;
            s_rd        <= '0;
            good_frames <= '0;
            bad_frames  <= '0;
        end else begin
            if (stat_stb && !stat_full) begin
                s_wr <= s_wr + 1'b1;
            end
            if (frame_done) begin
                s_rd <= s_rd + 1'b1;
                if (head.bad) begin
                    bad_frames <= bad_frames + 1'b1;
                end else begin
                    good_frames <= good_frames + 1'b1;
                end
            end
        end
    end

    // status leaves the monitor together with the last word
    a_last_has_stat : assert property (@(posedge clk) disable iff (!rst_n)
        (q_valid && q.last) |-> stat_valid);

endmodule

// File: rtl/mac_rx_path.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mac receive path top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mac_rx_path
    import mac_rx_pkg::*;
#(
    parameter int MIN_FRAME_LEN = 64,
    parameter int MAX_FRAME_LEN = 1518,
    parameter int FIFO_DEPTH    = 512,
    parameter int STAT_DEPTH    = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  byte_t      rx_data,
    input  logic       rx_valid,
    input  logic       rx_sof,
    input  logic       rx_eof,
    input  logic       rx_err,
    output word_t      m_data,
    output keep_t      m_keep,
    output logic       m_last,
    output logic       m_bad,
    output frame_len_t m_len,
    output logic       m_valid,
    input  logic       m_ready,
    output logic       overflow,
    output frame_cnt_t good_frames,
    output frame_cnt_t bad_frames
);

    logic       word_stb;
    rx_word_s   word;
    logic       stat_stb;
    rx_status_s stat;
    rx_word_s   q;
    logic       q_valid;
    logic       q_pop;

    rx_word_packer i_rx_word_packer (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_sof   (rx_sof),
        .rx_eof   (rx_eof),
        .word_stb (word_stb),
        .word     (word)
    );

    rx_frame_monitor #(
        .MIN_FRAME_LEN (MIN_FRAME_LEN),
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) i_rx_frame_monitor (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_sof   (rx_sof),
        .rx_eof   (rx_eof),
        .rx_err   (rx_err),
        .stat_stb (stat_stb),
        .stat     (stat)
    );

    rx_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_rx_word_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_stb   (word_stb),
        .wr_word  (word),
        .q        (q),
        .q_valid  (q_valid),
        .q_pop    (q_pop),
        .overflow (overflow)
    );

    rx_frame_tagger #(
        .STAT_DEPTH (STAT_DEPTH)
    ) i_rx_frame_tagger (
        .clk         (clk),
        .rst_n       (rst_n),
        .stat_stb    (stat_stb),
        .stat        (stat),
        .q           (q),
        .q_valid     (q_valid),
        .q_pop       (q_pop),
        .m_data      (m_data),
        .m_keep      (m_keep),
        .m_last      (m_last),
        .m_bad       (m_bad),
        .m_len       (m_len),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .good_frames (good_frames),
        .bad_frames  (bad_frames)
    );

endmodule

// File: testbench/tb_mac_rx_path.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the mac receive path
// frame table, beat scoreboard, watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_mac_rx_path
    import mac_rx_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int N_ROWS      = 17;
    localparam int ROW_CYCLES  = 200;
    // table rows plus the overflow frame and the frame after reset
    localparam int WATCHDOG_NS = (N_ROWS + 2) * ROW_CYCLES * CLK_PERIOD;

    typedef struct packed {
        int   len;
        int   err_pos;      // -1 for a clean frame
        logic rand_ready;
        logic bad;
    } row_t;

    typedef struct packed {
        word_t      data;
        keep_t      keep;
        logic       last;
        logic       bad;
        frame_len_t len;
    } beat_t;

    row_t rows [N_ROWS] = '{
        '{8,  -1, 1'b0, 1'b0},
        '{9,  -1, 1'b0, 1'b0},
        '{10, -1, 1'b0, 1'b0},
        '{11, -1, 1'b0, 1'b0},
        '{40, -1, 1'b0, 1'b0},
        '{1,  -1, 1'b0, 1'b1},      // sof and eof on one byte
        '{7,  -1, 1'b0, 1'b1},
        '{41, -1, 1'b0, 1'b1},
        '{20, 5,  1'b0, 1'b1},
        '{12, 0,  1'b0, 1'b1},
        '{23, 22, 1'b0, 1'b1},      // error on the eof byte
        '{33, -1, 1'b1, 1'b0},
        '{40, -1, 1'b1, 1'b0},
        '{3,  -1, 1'b1, 1'b1},
        '{45, -1, 1'b1, 1'b1},
        '{16, 9,  1'b1, 1'b1},
        '{25, -1, 1'b1, 1'b0}
    };

    logic       clk;
    logic       rst_n;
    byte_t      rx_data;
    logic       rx_valid;
    logic       rx_sof;
    logic       rx_eof;
    logic       rx_err;
    word_t      m_data;
    keep_t      m_keep;
    logic       m_last;
    logic       m_bad;
    frame_len_t m_len;
    logic       m_valid;
    logic       m_ready;
    logic       overflow;
    frame_cnt_t good_frames;
    frame_cnt_t bad_frames;

    beat_t      exp_q [$];
    beat_t      exp_beat;
    beat_t      held;
    logic       held_valid;
    logic       ready_rand;
    logic       ready_low;
    integer     seed;
    logic [31:0] rnd;
    logic [31:0] mask;
    byte_t      next_byte;
    row_t       extra;
    int         errors;
    int         checks;
    int         exp_good;
    int         exp_bad;
    int         r;

    mac_rx_path #(
        .MIN_FRAME_LEN (8),
        .MAX_FRAME_LEN (40),
        .FIFO_DEPTH    (16),
        .STAT_DEPTH    (8)
    ) i_mac_rx_path (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_sof      (rx_sof),
        .rx_eof      (rx_eof),
        .rx_err      (rx_err),
        .m_data      (m_data),
        .m_keep      (m_keep),
        .m_last      (m_last),
        .m_bad       (m_bad),
        .m_len       (m_len),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .overflow    (overflow),
        .good_frames (good_frames),
        .bad_frames  (bad_frames)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // drives one frame and queues the beats it should produce
    task automatic send_frame(input row_t row);
        word_t acc;
        keep_t keep;
        beat_t beat;
        int    lane;
        int    i;
        acc  = '0;
        keep = '0;
        lane = 0;
        for (i = 0; i < row.len; i++) begin
            @(negedge clk);
            rx_valid = 1'b1;
            rx_data  = next_byte;
            rx_sof   = (i == 0);
            rx_eof   = (i == row.len - 1);
            rx_err   = (i == row.err_pos);
            acc[lane*8 +: 8] = next_byte;
            keep[lane]       = 1'b1;
            next_byte++;
            lane++;
            if (lane == 4 || rx_eof) begin
                beat.data = acc;
                beat.keep = keep;
                beat.last = rx_eof;
                beat.bad  = rx_eof ? row.bad : 1'b0;
                beat.len  = rx_eof ? frame_len_t'(row.len) : '0;
                exp_q.push_back(beat);
                acc  = '0;
                keep = '0;
                lane = 0;
            end
        end
        @(negedge clk);
        rx_valid = 1'b0;
        rx_sof   = 1'b0;
        rx_eof   = 1'b0;
        rx_err   = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_counters();
        check("good_frames", good_frames, exp_good);
        check("bad_frames", bad_frames, exp_bad);
    endtask

    always @(negedge clk) begin
        rnd = $random(seed);
        if (ready_low) begin
            m_ready = 1'b0;
        end else if (ready_rand) begin
            m_ready = rnd[0];
        end else begin
            m_ready = 1'b1;
        end
    end

    // scoreboard on every transferred beat
    always @(posedge clk) begin
        if (!rst_n) begin
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin       // stalled beat must not move
                check("m_valid (stalled)", m_valid, 1'b1);
                check("m_data (stalled)", m_data, held.data);
                check("m_keep (stalled)", m_keep, held.keep);
                check("m_last (stalled)", m_last, held.last);
                check("m_bad (stalled)", m_bad, held.bad);
                check("m_len (stalled)", m_len, held.len);
            end
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t ns: output beat with no frame data pending",
                             $time);
                end else begin
                    exp_beat = exp_q.pop_front();
                    mask = {{8{exp_beat.keep[3]}}, {8{exp_beat.keep[2]}},
                            {8{exp_beat.keep[1]}}, {8{exp_beat.keep[0]}}};
                    check("m_data", m_data & mask, exp_beat.data);
                    check("m_keep", m_keep, exp_beat.keep);
                    check("m_last", m_last, exp_beat.last);
                    check("m_bad", m_bad, exp_beat.bad);
                    check("m_len", m_len, exp_beat.len);
                end
            end
            held_valid = m_valid && !m_ready;
            held       = '{m_data, m_keep, m_last, m_bad, m_len};
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Error at %0t ns: watchdog expired before the tests finished", $time);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Verification failed");
        $finish;
    end

    initial begin
        errors     = 0;
        checks     = 0;
        exp_good   = 0;
        exp_bad    = 0;
        next_byte  = '0;
        seed       = 32'hdf9b;
        rst_n      = 1'b0;
        rx_data    = '0;
        rx_valid   = 1'b0;
        rx_sof     = 1'b0;
        rx_eof     = 1'b0;
        rx_err     = 1'b0;
        m_ready    = 1'b1;
        ready_rand = 1'b0;
        ready_low  = 1'b0;
        held_valid = 1'b0;

        apply_reset();
        check("overflow", overflow, 1'b0);
        check_counters();

        for (r = 0; r < N_ROWS; r++) begin
            ready_rand = rows[r].rand_ready;
            send_frame(rows[r]);
            if (rows[r].bad) begin
                exp_bad++;
            end else begin
                exp_good++;
            end
            wait_drain();
            check_counters();
        end

        // output stalled for a whole 80-byte frame
        ready_rand = 1'b0;
        ready_low  = 1'b1;
        extra      = '{80, -1, 1'b0, 1'b1};
        send_frame(extra);
        check("overflow", overflow, 1'b1);

        apply_reset();
        exp_q.delete();
        exp_good = 0;
        exp_bad  = 0;
        check("overflow", overflow, 1'b0);
        check_counters();

        ready_low  = 1'b0;
        ready_rand = 1'b1;
        extra      = '{24, -1, 1'b1, 1'b0};
        send_frame(extra);
        exp_good++;
        wait_drain();
        check_counters();
        check("overflow", overflow, 1'b0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: build.f
rtl/mac_rx_pkg.sv
rtl/rx_word_packer.sv
rtl/rx_frame_monitor.sv
rtl/rx_word_fifo.sv
rtl/rx_frame_tagger.sv
rtl/mac_rx_path.sv
testbench/tb_mac_rx_path.sv
